//--- Makefile
TOP := controlUnitTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f compile.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir

//--- bench/controlUnitTb.sv
`timescale 1ns/100ps
`include "ctrl_defines.svh"

module controlUnitTb;

    import ctrlPkg::*;

    localparam int NUM_INSTR  = 120;
    localparam int TIMEOUT_NS = NUM_INSTR * (6 + 3 + 12 + 4) * 8 + 4000;

    // Reference model states
    localparam int M_FETCH   = 0;
    localparam int M_PRE     = 1;
    localparam int M_PRE2    = 2;
    localparam int M_EXEC    = 3;
    localparam int M_SAVE    = 4;
    localparam int M_EXIMM   = 5;
    localparam int M_SAVEIMM = 6;
    localparam int M_BR      = 7;
    localparam int M_TAKEN   = 8;
    localparam int M_START   = 9;
    localparam int M_WAIT    = 10;
    localparam int M_RESULT  = 11;
    localparam int M_MOVE    = 12;
    localparam int M_HALT    = 13;

    logic clk = 1'b0;
    logic reset;
    logic [`CTRL_OPCODE_W-1:0] opcode;
    logic [`CTRL_FUNCT_W-1:0] funct;
    logic overflow, greater, less, equal, multEnd, divEnd;
    logic writePc, writeA, writeB, writeAluOut, writeInstruction;
    logic writeReg, writeHiLo, multStart, divStart, hiLoSel;
    logic [`CTRL_ALUSRCA_W-1:0] aluSrcA;
    logic [`CTRL_ALUSRCB_W-1:0] aluSrcB;
    logic [`CTRL_PCSRC_W-1:0] pcSrc;
    logic [`CTRL_WRREG_W-1:0] writeRegSel;
    logic [`CTRL_WRDATA_W-1:0] writeDataSel;
    logic [`CTRL_ALUCTRL_W-1:0] aluCtrl;

    int mState;
    logic [1:0] mPhase;
    logic [5:0] mOp;
    logic [5:0] mFn;
    int seed = 32'h50a5;
    int issued = 0;
    int strobeErrors = 0;
    int selectErrors = 0;

    logic [8:0] actStrobes;
    string strobeNames [0:8] = '{"divStart", "multStart", "writeHiLo", "writeReg",
        "writeInstruction", "writeAluOut", "writeB", "writeA", "writePc"};

    assign actStrobes = {writePc, writeA, writeB, writeAluOut, writeInstruction,
                         writeReg, writeHiLo, multStart, divStart};

    controlUnit i_controlUnit (.*);

    initial begin
        forever #4 clk = ~clk;
    end

    function automatic int firstExec(input logic [5:0] op, input logic [5:0] fn);
        if (op == OP_ADDI || op == OP_ADDIU) return M_EXIMM;
        if (op inside {OP_BEQ, OP_BNE, OP_BLE, OP_BGT}) return M_BR;
        if (op != OP_R_TYPE) return M_HALT;
        case (fn)
            FN_ADD, FN_AND, FN_SUB: return M_EXEC;
            FN_MULT, FN_DIV:        return M_START;
            FN_MFHI, FN_MFLO:       return M_MOVE;
            default:                return M_HALT; // Dropped functs
        endcase
    endfunction

    function automatic logic branchHolds(input logic [5:0] op, input logic eq,
                                         input logic lt, input logic gt);
        case (op)
            OP_BEQ:  return eq;
            OP_BNE:  return !eq;
            OP_BLE:  return eq || lt;
            default: return gt;
        endcase
    endfunction

    function automatic logic [`CTRL_ALUCTRL_W-1:0] aluFor(input logic [5:0] fn);
        if (fn == FN_AND) return `CTRL_ALU_AND;
        if (fn == FN_SUB) return `CTRL_ALU_SUB;
        return `CTRL_ALU_ADD;
    endfunction

    // {writePc, writeA, writeB, writeAluOut, writeInstruction, writeReg, writeHiLo,
    //  multStart, divStart}
    function automatic logic [8:0] expectedStrobes(input int st, input logic [1:0] ph);
        case (st)
            M_FETCH:           return (ph == 2'd3) ? 9'b100000000 : 9'b000110000;
            M_PRE:             return 9'b000100000;
            M_PRE2:            return 9'b011000000;
            M_EXEC, M_EXIMM:   return 9'b000100000;
            M_SAVE, M_SAVEIMM: return 9'b000001000;
            M_MOVE:            return 9'b000001000;
            M_TAKEN:           return 9'b100000000;
            M_START:           return (mFn == FN_DIV) ? 9'b000000001 : 9'b000000010;
            M_RESULT:          return 9'b000000100;
            default:           return 9'b000000000; // Compare, wait and halt
        endcase
    endfunction

    // Reference model with one transition per clock
    always @(posedge clk) begin
        if (reset) begin
            mState <= M_FETCH;
            mPhase <= 2'd0;
        end else begin
            mPhase <= 2'd0;
            case (mState)
                M_FETCH: begin
                    mPhase <= mPhase + 2'd1;
                    if (mPhase == 2'd3) begin
                        mState <= M_PRE;
                    end
                end
                M_PRE: mState <= M_PRE2;
                M_PRE2: begin
                    mOp    <= opcode;
                    mFn    <= funct;
                    mState <= firstExec(opcode, funct);
                end
                M_EXEC:  mState <= M_SAVE;
                M_SAVE:  mState <= overflow ? M_HALT : M_FETCH;
                M_EXIMM: mState <= (overflow && mOp == OP_ADDI) ? M_HALT : M_SAVEIMM;
                M_BR:    mState <= branchHolds(mOp, equal, less, greater) ? M_TAKEN : M_FETCH;
                M_START: mState <= M_WAIT;
                M_WAIT: begin
                    if ((mFn == FN_DIV) ? divEnd : multEnd) begin
                        mState <= M_RESULT;
                    end
                end
                M_HALT:  mState <= M_HALT;
                default: mState <= M_FETCH;
            endcase
        end
    end

    task automatic checkValue(input string name, input int expected, input int actual,
                              input bit isStrobe);
        assert (expected == actual) else begin
            if (isStrobe) begin
                strobeErrors++;
            end else begin
                selectErrors++;
            end
            $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, expected,
                     actual);
        end
    endtask

    task automatic checkAlu(input logic [`CTRL_ALUSRCA_W-1:0] a,
                            input logic [`CTRL_ALUSRCB_W-1:0] b,
                            input logic [`CTRL_ALUCTRL_W-1:0] op);
        checkValue("aluSrcA", int'(a), int'(aluSrcA), 1'b0);
        checkValue("aluSrcB", int'(b), int'(aluSrcB), 1'b0);
        checkValue("aluCtrl", int'(op), int'(aluCtrl), 1'b0);
    endtask

    task automatic checkWrite(input logic [`CTRL_WRREG_W-1:0] regSel,
                              input logic [`CTRL_WRDATA_W-1:0] dataSel);
        checkValue("writeRegSel", int'(regSel), int'(writeRegSel), 1'b0);
        checkValue("writeDataSel", int'(dataSel), int'(writeDataSel), 1'b0);
    endtask

    // Only selects that the datapath uses in this state
    task automatic checkSelects();
        case (mState)
            M_FETCH: begin
                checkAlu(`CTRL_ALUSRCA_PC, `CTRL_ALUSRCB_FOUR, `CTRL_ALU_ADD);
                if (mPhase == 2'd3) begin
                    checkValue("pcSrc", int'(`CTRL_PCSRC_ALU_RESULT), int'(pcSrc), 1'b0);
                end
            end
            M_PRE:     checkAlu(`CTRL_ALUSRCA_PC, `CTRL_ALUSRCB_SIGN_IMM, `CTRL_ALU_ADD);
            M_EXEC:    checkAlu(`CTRL_ALUSRCA_REG_A, `CTRL_ALUSRCB_REG_B, aluFor(mFn));
            M_EXIMM:   checkAlu(`CTRL_ALUSRCA_REG_A, `CTRL_ALUSRCB_SIGN_IMM, `CTRL_ALU_ADD);
            M_BR:      checkAlu(`CTRL_ALUSRCA_REG_A, `CTRL_ALUSRCB_REG_B, `CTRL_ALU_COMPARE);
            M_TAKEN:   checkValue("pcSrc", int'(`CTRL_PCSRC_ALU_OUT), int'(pcSrc), 1'b0);
            M_SAVE:    checkWrite(`CTRL_WRREG_RD, `CTRL_WRDATA_ALU_OUT);
            M_SAVEIMM: checkWrite(`CTRL_WRREG_RT, `CTRL_WRDATA_ALU_OUT);
            M_MOVE:    checkWrite(`CTRL_WRREG_RD,
                                  (mFn == FN_MFHI) ? `CTRL_WRDATA_HI : `CTRL_WRDATA_LO);
            M_RESULT:  checkValue("hiLoSel", int'(mFn == FN_DIV), int'(hiLoSel), 1'b0);
            default: begin
            end
        endcase
    endtask

    // Outputs are settled mid cycle
    always @(negedge clk) begin
        logic [8:0] expStrobes;
        expStrobes = reset ? 9'd0 : expectedStrobes(mState, mPhase);
        for (int i = 0; i < 9; i++) begin
            checkValue(strobeNames[i], int'(expStrobes[i]), int'(actStrobes[i]), 1'b1);
        end
        if (reset) begin
            checkValue("hiLoSel", 0, int'(hiLoSel), 1'b1);
        end else begin
            checkSelects();
        end
    end

    task automatic pickInstruction(input logic [3:0] sel);
        opcode <= OP_R_TYPE;
        funct  <= FN_ADD;
        case (sel)
            4'd1:  funct <= FN_AND;
            4'd2:  funct <= FN_SUB;
            4'd3:  funct <= FN_MULT;
            4'd4:  funct <= FN_DIV;
            4'd5:  funct <= FN_MFHI;
            4'd6:  funct <= FN_MFLO;
            4'd7:  opcode <= OP_ADDI;
            4'd8:  opcode <= OP_ADDIU;
            4'd9:  opcode <= OP_BEQ;
            4'd10: opcode <= OP_BNE;
            4'd11: opcode <= OP_BLE;
            4'd12: opcode <= OP_BGT;
            4'd13: opcode <= 6'b100011; // lw is now unknown
            4'd14: funct <= 6'b000000;  // sll is now unknown
            default: begin
            end
        endcase
    endtask

    initial begin : stimulus
        int remaining;
        int halted;
        int st;
        logic [1:0] ph;
        logic [31:0] r;
        remaining = 0;
        halted = 0;
        reset = 1'b1;
        opcode = '0;
        funct = '0;
        overflow = 1'b0;
        greater = 1'b0;
        less = 1'b0;
        equal = 1'b0;
        multEnd = 1'b0;
        divEnd = 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        while (issued <= NUM_INSTR) begin
            @(negedge clk);
            st = mState;
            ph = mPhase;
            @(posedge clk);
            r = $random(seed);
            greater  <= r[0];
            less     <= r[1];
            equal    <= r[2];
            if (st == M_PRE2) begin
                overflow <= r[3]; // Often during the immediate add
            end else begin
                overflow <= (r[5:3] == 3'b000); // Rare trap
            end
            if (st == M_FETCH && ph == 2'd0 && !reset) begin
                issued++;
                pickInstruction(r[19:16]);
            end
            if (st == M_START) begin
                remaining = 1 + int'(r[15:8]) % 12;
            end else if (st == M_WAIT) begin
                remaining--;
            end else begin
                remaining = 0;
            end
            multEnd <= (remaining == 1) && (mFn != FN_DIV);
            divEnd  <= (remaining == 1) && (mFn == FN_DIV);
            halted = (st == M_HALT) ? halted + 1 : 0;
            reset <= (halted >= 3); // Recover from a halt
        end
        $display("Checks done: %0d strobe errors, %0d select errors",
                 strobeErrors, selectErrors);
        if (strobeErrors == 0 && selectErrors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin : watchdog
        #TIMEOUT_NS;
        $display("Timeout: the instruction stream did not finish within %0d ns",
                 TIMEOUT_NS);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- compile.f
+incdir+source
source/ctrlPkg.sv
source/instrDecoder.sv
source/cycleSequencer.sv
source/controlWordGen.sv
source/controlUnit.sv
bench/controlUnitTb.sv

//--- source/controlUnit.sv
`timescale 1ns/100ps
`include "ctrl_defines.svh"

module controlUnit (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`CTRL_OPCODE_W-1:0]  opcode,
    input  logic [`CTRL_FUNCT_W-1:0]   funct,
    input  logic                       overflow,
    input  logic                       greater,
    input  logic                       less,
    input  logic                       equal,
    input  logic                       multEnd,
    input  logic                       divEnd,
    output logic                       writePc,
    output logic                       writeA,
    output logic                       writeB,
    output logic                       writeAluOut,
    output logic                       writeInstruction,
    output logic                       writeReg,
    output logic                       writeHiLo,
    output logic                       multStart,
    output logic                       divStart,
    output logic                       hiLoSel,
    output logic [`CTRL_ALUSRCA_W-1:0] aluSrcA,
    output logic [`CTRL_ALUSRCB_W-1:0] aluSrcB,
    output logic [`CTRL_PCSRC_W-1:0]   pcSrc,
    output logic [`CTRL_WRREG_W-1:0]   writeRegSel,
    output logic [`CTRL_WRDATA_W-1:0]  writeDataSel,
    output logic [`CTRL_ALUCTRL_W-1:0] aluCtrl
);

    import ctrlPkg::*;

    state_e                   execState;
    state_e                   state;
    logic [`CTRL_PHASE_W-1:0] phase;

    instrDecoder i_instrDecoder (
        .opcode    (opcode_e'(opcode)), // Unknown codes fall to the default arm
        .funct     (funct_e'(funct)),
        .execState (execState)
    );

    cycleSequencer i_cycleSequencer (
        .clk       (clk),
        .reset     (reset),
        .execState (execState),
        .overflow  (overflow),
        .greater   (greater),
        .less      (less),
        .equal     (equal),
        .multEnd   (multEnd),
        .divEnd    (divEnd),
        .state     (state),
        .phase     (phase)
    );

    controlWordGen i_controlWordGen (
        .reset            (reset),
        .state            (state),
        .phase            (phase),
        .writePc          (writePc),
        .writeA           (writeA),
        .writeB           (writeB),
        .writeAluOut      (writeAluOut),
        .writeInstruction (writeInstruction),
        .writeReg         (writeReg),
        .writeHiLo        (writeHiLo),
        .multStart        (multStart),
        .divStart         (divStart),
        .hiLoSel          (hiLoSel),
        .aluSrcA          (aluSrcA),
        .aluSrcB          (aluSrcB),
        .pcSrc            (pcSrc),
        .writeRegSel      (writeRegSel),
        .writeDataSel     (writeDataSel),
        .aluCtrl          (aluCtrl)
    );

endmodule

//--- source/controlWordGen.sv
`timescale 1ns/100ps
`include "ctrl_defines.svh"

module controlWordGen (
    input  logic                       reset,
    input  ctrlPkg::state_e            state,
    input  logic [`CTRL_PHASE_W-1:0]   phase,
    output logic                       writePc,
    output logic                       writeA,
    output logic                       writeB,
    output logic                       writeAluOut,
    output logic                       writeInstruction,
    output logic                       writeReg,
    output logic                       writeHiLo,
    output logic                       multStart,
    output logic                       divStart,
    output logic                       hiLoSel,
    output logic [`CTRL_ALUSRCA_W-1:0] aluSrcA,
    output logic [`CTRL_ALUSRCB_W-1:0] aluSrcB,
    output logic [`CTRL_PCSRC_W-1:0]   pcSrc,
    output logic [`CTRL_WRREG_W-1:0]   writeRegSel,
    output logic [`CTRL_WRDATA_W-1:0]  writeDataSel,
    output logic [`CTRL_ALUCTRL_W-1:0] aluCtrl
);

    import ctrlPkg::*;

    always_comb begin
        writePc          = 1'b0;
        writeA           = 1'b0;
        writeB           = 1'b0;
        writeAluOut      = 1'b0;
        writeInstruction = 1'b0;
        writeReg         = 1'b0;
        writeHiLo        = 1'b0;
        multStart        = 1'b0;
        divStart         = 1'b0;
        hiLoSel          = 1'b0;
        aluSrcA          = `CTRL_ALUSRCA_PC;
        aluSrcB          = `CTRL_ALUSRCB_REG_B;
        pcSrc            = `CTRL_PCSRC_ALU_RESULT;
        writeRegSel      = `CTRL_WRREG_RD;
        writeDataSel     = `CTRL_WRDATA_ALU_OUT;
        aluCtrl          = `CTRL_ALU_ADD;

        case (state)
            FETCH: begin
                aluSrcB = `CTRL_ALUSRCB_FOUR; // PC + 4 in every phase
                if (phase == '1) begin
                    writePc = 1'b1;
                end else begin
                    writeInstruction = 1'b1;
                    writeAluOut      = 1'b1;
                end
            end
            PRECALC: begin
                writeAluOut = 1'b1; // Branch target into ALUOut
                aluSrcB     = `CTRL_ALUSRCB_SIGN_IMM;
            end
            PRECALC2: begin
                writeA = 1'b1;
                writeB = 1'b1;
            end
            EX_ADD, EX_AND, EX_SUB: begin
                writeAluOut = 1'b1;
                aluSrcA     = `CTRL_ALUSRCA_REG_A;
                if (state == EX_AND) begin
                    aluCtrl = `CTRL_ALU_AND;
                end else if (state == EX_SUB) begin
                    aluCtrl = `CTRL_ALU_SUB;
                end
            end
            SAVE_RESULT: begin
                writeReg = 1'b1;
            end
            EX_ADDI, EX_ADDIU: begin
                writeAluOut = 1'b1;
                aluSrcA     = `CTRL_ALUSRCA_REG_A;
                aluSrcB     = `CTRL_ALUSRCB_SIGN_IMM;
            end
            SAVE_IMM: begin
                writeReg    = 1'b1;
                writeRegSel = `CTRL_WRREG_RT;
            end
            MULT_START:  multStart = 1'b1;
            MULT_RESULT: writeHiLo = 1'b1;
            DIV_START:   divStart  = 1'b1;
            DIV_RESULT: begin
                writeHiLo = 1'b1;
                hiLoSel   = 1'b1; // Divider result
            end
            MFHI: begin
                writeReg     = 1'b1;
                writeDataSel = `CTRL_WRDATA_HI;
            end
            MFLO: begin
                writeReg     = 1'b1;
                writeDataSel = `CTRL_WRDATA_LO;
            end
            BR_EQ, BR_NE, BR_LE, BR_GT: begin
                aluSrcA = `CTRL_ALUSRCA_REG_A;
                aluCtrl = `CTRL_ALU_COMPARE;
            end
            BRANCH_TAKEN: begin
                writePc = 1'b1;
                pcSrc   = `CTRL_PCSRC_ALU_OUT;
            end
            default: begin
            end
        endcase

        if (reset) begin
            writePc          = 1'b0;
            writeA           = 1'b0;
            writeB           = 1'b0;
            writeAluOut      = 1'b0;
            writeInstruction = 1'b0;
            writeReg         = 1'b0;
            writeHiLo        = 1'b0;
            multStart        = 1'b0;
            divStart         = 1'b0;
            hiLoSel          = 1'b0;
        end
    end

endmodule

//--- source/ctrlPkg.sv
`include "ctrl_defines.svh"

package ctrlPkg;

    typedef enum logic [`CTRL_OPCODE_W-1:0] {
        OP_R_TYPE = 6'b000000,
        OP_ADDI   = 6'b001000,
        OP_ADDIU  = 6'b001001,
        OP_BEQ    = 6'b000100,
        OP_BNE    = 6'b000101,
        OP_BLE    = 6'b000110,
        OP_BGT    = 6'b000111
    } opcode_e;

    typedef enum logic [`CTRL_FUNCT_W-1:0] {
        FN_ADD  = 6'b100000,
        FN_AND  = 6'b100100,
        FN_SUB  = 6'b100010,
        FN_MULT = 6'b011000,
        FN_DIV  = 6'b011010,
        FN_MFHI = 6'b010000,
        FN_MFLO = 6'b010010
    } funct_e;

    typedef enum logic [4:0] {
        FETCH,
        PRECALC,
        PRECALC2,
        EX_ADD,
        EX_AND,
        EX_SUB,
        SAVE_RESULT,
        EX_ADDI,
        EX_ADDIU,
        SAVE_IMM,
        MULT_START,
        MULT_WAIT,
        MULT_RESULT,
        DIV_START,
        DIV_WAIT,
        DIV_RESULT,
        MFHI,
        MFLO,
        BR_EQ,
        BR_NE,
        BR_LE,
        BR_GT,
        BRANCH_TAKEN,
        OPCODE_ERROR,  // Halts until reset
        OVERFLOW_HALT  // Halts until reset
    } state_e;

endpackage

//--- source/ctrl_defines.svh
`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

// Instruction field widths
`define CTRL_OPCODE_W  6
`define CTRL_FUNCT_W   6
`define CTRL_PHASE_W   2

// Datapath select widths
`define CTRL_ALUSRCA_W 2
`define CTRL_ALUSRCB_W 3
`define CTRL_PCSRC_W   2
`define CTRL_WRREG_W   2
`define CTRL_WRDATA_W  3
`define CTRL_ALUCTRL_W 3

`define CTRL_ALUSRCA_PC        2'b00
`define CTRL_ALUSRCA_REG_A     2'b01

`define CTRL_ALUSRCB_REG_B     3'b000
`define CTRL_ALUSRCB_FOUR      3'b001
`define CTRL_ALUSRCB_SIGN_IMM  3'b010

`define CTRL_PCSRC_ALU_RESULT  2'b00 // Straight from the ALU
`define CTRL_PCSRC_ALU_OUT     2'b10 // Registered branch target

`define CTRL_WRREG_RD          2'b00
`define CTRL_WRREG_RT          2'b01

`define CTRL_WRDATA_ALU_OUT    3'b000
`define CTRL_WRDATA_LO         3'b001
`define CTRL_WRDATA_HI         3'b010

`define CTRL_ALU_ADD           3'b001
`define CTRL_ALU_SUB           3'b010
`define CTRL_ALU_AND           3'b011
`define CTRL_ALU_COMPARE       3'b111 // Sets greater, less and equal

`endif

//--- source/cycleSequencer.sv
`timescale 1ns/100ps
`include "ctrl_defines.svh"

module cycleSequencer (
    input  logic                     clk,
    input  logic                     reset,
    input  ctrlPkg::state_e          execState,
    input  logic                     overflow,
    input  logic                     greater,
    input  logic                     less,
    input  logic                     equal,
    input  logic                     multEnd,
    input  logic                     divEnd,
    output ctrlPkg::state_e          state,
    output logic [`CTRL_PHASE_W-1:0] phase
);

    import ctrlPkg::*;

    state_e nextState;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
            phase <= '0;
        end else begin
            state <= nextState;
            if (state == FETCH) begin
                phase <= phase + 1'b1; // Wraps to 0 on leaving fetch
            end else begin
                phase <= '0;
            end
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            FETCH: begin
                if (phase == '1) begin
                    nextState = PRECALC;
                end
            end
            PRECALC:  nextState = PRECALC2;
            PRECALC2: nextState = execState; // Instruction sampled here

            EX_ADD, EX_AND, EX_SUB: begin
                nextState = SAVE_RESULT;
            end
            SAVE_RESULT: begin
                nextState = overflow ? OVERFLOW_HALT : FETCH;
            end

            EX_ADDI: begin
                nextState = overflow ? OVERFLOW_HALT : SAVE_IMM;
            end
            EX_ADDIU: nextState = SAVE_IMM; // Unsigned add never traps
            SAVE_IMM: nextState = FETCH;

            MULT_START: nextState = MULT_WAIT;
            MULT_WAIT: begin
                if (multEnd) begin
                    nextState = MULT_RESULT;
                end
            end
            MULT_RESULT: nextState = FETCH;

            DIV_START: nextState = DIV_WAIT;
            DIV_WAIT: begin
                if (divEnd) begin
                    nextState = DIV_RESULT;
                end
            end
            DIV_RESULT: nextState = FETCH;

            MFHI, MFLO: nextState = FETCH;

            // Flags come from the compare in this same cycle
            BR_EQ: nextState = equal ? BRANCH_TAKEN : FETCH;
            BR_NE: nextState = !equal ? BRANCH_TAKEN : FETCH;
            BR_LE: nextState = (equal || less) ? BRANCH_TAKEN : FETCH;
            BR_GT: nextState = greater ? BRANCH_TAKEN : FETCH;
            BRANCH_TAKEN: nextState = FETCH;

            OPCODE_ERROR, OVERFLOW_HALT: begin
                nextState = state;
            end
            default: begin
                nextState = OPCODE_ERROR;
            end
        endcase
    end

endmodule

//--- source/instrDecoder.sv
`timescale 1ns/100ps

module instrDecoder (
    input  ctrlPkg::opcode_e opcode,
    input  ctrlPkg::funct_e  funct,
    output ctrlPkg::state_e  execState
);

    import ctrlPkg::*;

    state_e rTypeState;

    // R-type work is picked by funct
    always_comb begin
        case (funct)
            FN_ADD:  rTypeState = EX_ADD;
            FN_AND:  rTypeState = EX_AND;
            FN_SUB:  rTypeState = EX_SUB;
            FN_MULT: rTypeState = MULT_START;
            FN_DIV:  rTypeState = DIV_START;
            FN_MFHI: rTypeState = MFHI;
            FN_MFLO: rTypeState = MFLO;
            default: rTypeState = OPCODE_ERROR; // Shifts, jr, break and the rest
        endcase
    end

    always_comb begin
        case (opcode)
            OP_R_TYPE: begin
                execState = rTypeState;
            end
            OP_ADDI: begin
                execState = EX_ADDI;
            end
            OP_ADDIU: begin
                execState = EX_ADDIU;
            end
            OP_BEQ: begin
                execState = BR_EQ;
            end
            OP_BNE: begin
                execState = BR_NE;
            end
            OP_BLE: begin
                execState = BR_LE;
            end
            OP_BGT: begin
                execState = BR_GT;
            end
            default: begin
                execState = OPCODE_ERROR; // Loads, stores, jumps included
            end
        endcase
    end

endmodule
